/* pmp_pkg.sv */
// Shared types for the PMP unit, imported by every RTL module and by the testbench
package pmp_pkg;

   ////////////////////////////////////////////////////////////
   // Address types
   ////////////////////////////////////////////////////////////

   // Byte address as seen on the request ports
   typedef logic [31:0] addr_t;

   // Word address register value, holds byte address bits 33 to 2
   typedef logic [31:0] pmp_addr_t;

   ////////////////////////////////////////////////////////////
   // Enumerations
   ////////////////////////////////////////////////////////////

   // Privilege levels, encoded as in the privileged spec
   typedef enum logic [1:0] {
      PRIV_LVL_U = 2'd0,
      PRIV_LVL_S = 2'd1,
      PRIV_LVL_M = 2'd3
   } priv_lvl_e;

   // Address matching mode of one entry
   typedef enum logic [1:0] {
      OFF   = 2'd0,
      TOR   = 2'd1,
      NA4   = 2'd2,
      NAPOT = 2'd3
   } pmp_mode_e;

   // Kind of access being checked
   typedef enum logic [1:0] {
      ACC_READ  = 2'd0,
      ACC_WRITE = 2'd1,
      ACC_EXEC  = 2'd2
   } pmp_access_e;

   ////////////////////////////////////////////////////////////
   // Structures
   ////////////////////////////////////////////////////////////

   // Configuration byte, top bit first
   typedef struct packed {
      logic       lock;
      logic [1:0] rsvd;
      pmp_mode_e  mode;
      logic       x;
      logic       w;
      logic       r;
   } pmp_cfg_t;

   // One decoded entry, all addresses in words
   typedef struct packed {
      logic      en;
      pmp_mode_e mode;
      logic      r;
      logic      w;
      logic      x;
      pmp_addr_t base;
      pmp_addr_t mask;
      pmp_addr_t top;
   } pmp_region_t;

   // Word address of a byte address, zero-extended to register width
   function automatic pmp_addr_t to_word_addr(addr_t byte_addr);
      return {2'b00, byte_addr[31:2]};
   endfunction

endpackage

/* pmp_rule_decode.sv */
// Decodes the PMP configuration bytes and address registers into region descriptors
`timescale 1ns/1ps

module pmp_rule_decode
   import pmp_pkg::*;
#(
   parameter int N_ENTRIES = 16
)
(
   input  pmp_cfg_t    [N_ENTRIES-1:0] cfg_i,
   input  pmp_addr_t   [N_ENTRIES-1:0] addr_i,
   output pmp_region_t [N_ENTRIES-1:0] regions_o
);

   for (genvar i = 0; i < N_ENTRIES; i++)
   begin : g_entry

      pmp_addr_t   prev_addr;
      pmp_addr_t   napot_mask;
      logic        all_ones;
      pmp_region_t region;

      // TOR lower bound comes from the entry below, entry 0 starts at zero
      if (i == 0)
      begin : g_first
         assign prev_addr = '0;
      end
      else
      begin : g_chain
         assign prev_addr = addr_i[i-1];
      end

      ////////////////////////////////////////////////////////////
      // NAPOT mask from a trailing-ones scan
      ////////////////////////////////////////////////////////////

      // Bit k is cleared while every bit below it is one, so the
      // first zero is cleared as well
      always_comb
      begin
         logic run;
         run = 1'b1;
         for (int k = 0; k < 32; k++)
         begin
            napot_mask[k] = ~run;
            run           = run & addr_i[i][k];
         end
         all_ones = run;
      end

      ////////////////////////////////////////////////////////////
      // Mode decode
      ////////////////////////////////////////////////////////////

      always_comb
      begin
         region.en   = 1'b0;
         region.mode = cfg_i[i].mode;
         region.r    = cfg_i[i].r;
         region.w    = cfg_i[i].w;
         region.x    = cfg_i[i].x;
         region.base = addr_i[i];
         region.mask = '1;
         region.top  = addr_i[i];

         case (cfg_i[i].mode)
            TOR:
            begin
               region.en   = 1'b1;
               region.base = prev_addr;
            end
            NA4:
            begin
               region.en = 1'b1;
            end
            NAPOT:
            begin
               // An all-ones register has no zero bit to size the region
               region.en   = ~all_ones;
               region.mask = napot_mask;
               region.base = addr_i[i] & napot_mask;
            end
            default: ;
         endcase
      end

      assign regions_o[i] = region;

      // Enabled entries carry a real mode
      // Below the mask the register holds a run of ones closed by one zero
      always_comb
      begin
         assert final (!regions_o[i].en ||
                       (regions_o[i].mode != OFF &&
                        (addr_i[i] & ~regions_o[i].mask) == (~regions_o[i].mask >> 1)))
            else $error("entry %0d decoded inconsistently", i);
      end

   end

endmodule

/* pmp_access_check.sv */
// Checks one address and access kind against all decoded PMP regions
`timescale 1ns/1ps

module pmp_access_check
   import pmp_pkg::*;
#(
   parameter int N_ENTRIES = 16
)
(
   input  pmp_region_t [N_ENTRIES-1:0] regions_i,
   input  addr_t                       addr_i,
   input  pmp_access_e                 access_i,
   input  priv_lvl_e                   priv_i,
   output logic                        allowed_o
);

   pmp_addr_t            req_word;
   logic [N_ENTRIES-1:0] entry_hit;

   assign req_word = to_word_addr(addr_i);

   ////////////////////////////////////////////////////////////
   // Per-entry match
   ////////////////////////////////////////////////////////////

   for (genvar i = 0; i < N_ENTRIES; i++)
   begin : g_entry

      logic perm_ok;
      logic addr_hit;

      // Permission bit picked by the access kind
      always_comb
      begin
         case (access_i)
            ACC_READ:  perm_ok = regions_i[i].r;
            ACC_WRITE: perm_ok = regions_i[i].w;
            ACC_EXEC:  perm_ok = regions_i[i].x;
            default:   perm_ok = 1'b0;
         endcase
      end

      // NA4 uses an all-ones mask, so it shares the NAPOT compare
      always_comb
      begin
         case (regions_i[i].mode)
            TOR:
            begin
               addr_hit = (req_word >= regions_i[i].base) &&
                          (req_word <  regions_i[i].top);
            end
            NA4, NAPOT:
            begin
               addr_hit = (req_word & regions_i[i].mask) == regions_i[i].base;
            end
            default:
            begin
               addr_hit = 1'b0;
            end
         endcase
      end

      assign entry_hit[i] = regions_i[i].en & perm_ok & addr_hit;

   end

   ////////////////////////////////////////////////////////////
   // Final decision
   ////////////////////////////////////////////////////////////

   // Machine mode bypasses every rule
   assign allowed_o = (priv_i == PRIV_LVL_M) || (|entry_hit);

endmodule

/* pmp_data_gate.sv */
// Gates the data request and grant and holds the data access error until acknowledged
`timescale 1ns/1ps

module pmp_data_gate
(
   input  logic clk,
   input  logic rst_n,
   input  logic req_i,
   input  logic gnt_i,
   input  logic allowed_i,
   input  logic err_ack_i,
   output logic req_o,
   output logic gnt_o,
   output logic err_o
);

   typedef enum logic {
      IDLE,
      GIVE_ERROR
   } err_state_e;

   err_state_e state_q;
   err_state_e state_d;
   logic       deny;

   assign deny = req_i & ~allowed_i;

   // Handshake passes straight through when the access is allowed
   assign req_o = req_i & allowed_i;
   assign gnt_o = gnt_i & allowed_i;

   ////////////////////////////////////////////////////////////
   // Error FSM
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         IDLE:
         begin
            if (deny)
            begin
               state_d = GIVE_ERROR;
            end
         end
         GIVE_ERROR:
         begin
            // Held until the core acknowledges
            if (err_ack_i)
            begin
               state_d = IDLE;
            end
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q <= IDLE;
      end
      else
      begin
         state_q <= state_d;
      end
   end

   assign err_o = (state_q == GIVE_ERROR);

   // A denied request never reaches memory and is flagged on the next edge
   a_deny_flagged : assert property (
      @(posedge clk) disable iff (!rst_n)
      (deny && !(err_o && err_ack_i)) |-> !req_o ##1 err_o
   );

endmodule

/* pmp_top.sv */
// Top level of the PMP unit, placed between the core's data and fetch ports and memory
`timescale 1ns/1ps

module pmp_top
   import pmp_pkg::*;
#(
   parameter int N_ENTRIES = 16
)
(
   input  logic                        clk,
   input  logic                        rst_n,

   input  priv_lvl_e                   priv_i,
   input  pmp_cfg_t  [N_ENTRIES-1:0]   pmp_cfg_i,
   input  pmp_addr_t [N_ENTRIES-1:0]   pmp_addr_i,

   // Data side, core to PMP
   input  logic                        data_req_i,
   input  logic                        data_we_i,
   input  addr_t                       data_addr_i,
   output logic                        data_gnt_o,
   // Data side, PMP to memory
   output logic                        data_req_o,
   input  logic                        data_gnt_i,
   output addr_t                       data_addr_o,
   output logic                        data_err_o,
   input  logic                        data_err_ack_i,

   // Fetch side, core to PMP
   input  logic                        instr_req_i,
   input  addr_t                       instr_addr_i,
   output logic                        instr_gnt_o,
   // Fetch side, PMP to memory
   output logic                        instr_req_o,
   input  logic                        instr_gnt_i,
   output addr_t                       instr_addr_o,
   output logic                        instr_err_o
);

   pmp_region_t [N_ENTRIES-1:0] regions;
   pmp_access_e                 data_access;
   logic                        data_allowed;
   logic                        instr_allowed;

   ////////////////////////////////////////////////////////////
   // Rule decode, shared by both ports
   ////////////////////////////////////////////////////////////

   pmp_rule_decode #(
      .N_ENTRIES (N_ENTRIES)
   ) i_rule_decode (
      .cfg_i     (pmp_cfg_i),
      .addr_i    (pmp_addr_i),
      .regions_o (regions)
   );

   ////////////////////////////////////////////////////////////
   // Data port
   ////////////////////////////////////////////////////////////

   assign data_access = data_we_i ? ACC_WRITE : ACC_READ;

   pmp_access_check #(
      .N_ENTRIES (N_ENTRIES)
   ) i_data_check (
      .regions_i (regions),
      .addr_i    (data_addr_i),
      .access_i  (data_access),
      .priv_i    (priv_i),
      .allowed_o (data_allowed)
   );

   pmp_data_gate i_data_gate (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_i     (data_req_i),
      .gnt_i     (data_gnt_i),
      .allowed_i (data_allowed),
      .err_ack_i (data_err_ack_i),
      .req_o     (data_req_o),
      .gnt_o     (data_gnt_o),
      .err_o     (data_err_o)
   );

   assign data_addr_o = data_addr_i;

   ////////////////////////////////////////////////////////////
   // Fetch port
   ////////////////////////////////////////////////////////////

   pmp_access_check #(
      .N_ENTRIES (N_ENTRIES)
   ) i_instr_check (
      .regions_i (regions),
      .addr_i    (instr_addr_i),
      .access_i  (ACC_EXEC),
      .priv_i    (priv_i),
      .allowed_o (instr_allowed)
   );

   // Fetch error is combinational, no handshake with the core
   assign instr_req_o  = instr_req_i & instr_allowed;
   assign instr_gnt_o  = instr_gnt_i & instr_allowed;
   assign instr_err_o  = instr_req_i & ~instr_allowed;
   assign instr_addr_o = instr_addr_i;

endmodule

/* tb_pmp.sv */
// Directed testbench for the PMP top level, built from all.f with tb_pmp as the top module
`timescale 1ns/1ps

module tb_pmp
   import pmp_pkg::*;
();

   localparam int N_ENTRIES  = 16;
   // Tests take about 130 cycles, the limit leaves a wide margin
   localparam int MAX_CYCLES = 2000;
   localparam int DRIVE_DLY  = 10;
   localparam int SAMPLE_DLY = 80;

   logic                      clk;
   logic                      rst_n;
   priv_lvl_e                 priv_i;
   pmp_cfg_t  [N_ENTRIES-1:0] pmp_cfg_i;
   pmp_addr_t [N_ENTRIES-1:0] pmp_addr_i;
   logic                      data_req_i;
   logic                      data_we_i;
   addr_t                     data_addr_i;
   logic                      data_gnt_o;
   logic                      data_req_o;
   logic                      data_gnt_i;
   addr_t                     data_addr_o;
   logic                      data_err_o;
   logic                      data_err_ack_i;
   logic                      instr_req_i;
   addr_t                     instr_addr_i;
   logic                      instr_gnt_o;
   logic                      instr_req_o;
   logic                      instr_gnt_i;
   addr_t                     instr_addr_o;
   logic                      instr_err_o;

   int                        errors;
   int                        checks;
   int                        tests;
   int                        test_start;
   int                        cycles = 0;
   logic [31:0]               lcg_state;

   pmp_top #(
      .N_ENTRIES (N_ENTRIES)
   ) i_dut (.*);

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles == MAX_CYCLES)
      begin
         $display("timeout: tests did not complete within %0d cycles", MAX_CYCLES);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Lock and reserved bits stay zero
   function automatic pmp_cfg_t make_cfg(pmp_mode_e mode, logic x, logic w, logic r);
      return '{1'b0, 2'b00, mode, x, w, r};
   endfunction

   task automatic check_bit(string name, logic exp, logic act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("mismatch %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_addr(string name, addr_t exp, addr_t act);
      checks++;
      if (act !== exp)
      begin
         errors++;
         $display("mismatch %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   // Wait for the edge, then step to the drive point
   task automatic end_cycle();
      @(posedge clk);
      #DRIVE_DLY;
   endtask

   task automatic report_test(string name);
      tests++;
      $display("test %s done, %0d errors", name, errors - test_start);
   endtask

   // One data access with memory granting at once
   task automatic check_data(string name, addr_t addr, logic we, logic exp_ok);
      data_req_i  = 1'b1;
      data_we_i   = we;
      data_addr_i = addr;
      data_gnt_i  = 1'b1;
      #SAMPLE_DLY;
      check_bit({name, " req"}, exp_ok, data_req_o);
      check_bit({name, " gnt"}, exp_ok, data_gnt_o);
      end_cycle();
      data_req_i = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////

   task automatic test_machine_bypass();
      addr_t a;
      addr_t b;
      test_start   = errors;
      a            = next_rand();
      b            = next_rand();
      priv_i       = PRIV_LVL_M;
      pmp_cfg_i    = '0;
      data_req_i   = 1'b1;
      data_we_i    = 1'b1;
      data_addr_i  = a;
      data_gnt_i   = 1'b0;
      instr_req_i  = 1'b1;
      instr_addr_i = b;
      instr_gnt_i  = 1'b0;
      #SAMPLE_DLY;
      check_bit("bypass data req", 1'b1, data_req_o);
      check_bit("bypass data gnt low", 1'b0, data_gnt_o);
      check_bit("bypass fetch req", 1'b1, instr_req_o);
      check_bit("bypass fetch gnt low", 1'b0, instr_gnt_o);
      check_addr("bypass data addr", a, data_addr_o);
      check_addr("bypass fetch addr", b, instr_addr_o);
      end_cycle();
      data_gnt_i  = 1'b1;
      instr_gnt_i = 1'b1;
      #SAMPLE_DLY;
      check_bit("bypass data gnt", 1'b1, data_gnt_o);
      check_bit("bypass fetch gnt", 1'b1, instr_gnt_o);
      check_bit("bypass data err", 1'b0, data_err_o);
      check_bit("bypass fetch err", 1'b0, instr_err_o);
      end_cycle();
      data_req_i  = 1'b0;
      instr_req_i = 1'b0;
      #SAMPLE_DLY;
      check_bit("bypass data idle", 1'b0, data_req_o);
      check_bit("bypass fetch idle", 1'b0, instr_req_o);
      end_cycle();
      report_test("machine bypass");
   endtask

   task automatic test_na4_tor();
      test_start = errors;
      priv_i     = PRIV_LVL_U;
      pmp_cfg_i  = '0;
      pmp_addr_i = '0;
      // Entry 0 is TOR from word zero up to word 0x40
      pmp_addr_i[0] = 32'h0000_0040;
      pmp_cfg_i[0]  = make_cfg(TOR, 1'b0, 1'b0, 1'b1);
      // Entries 1 and 2 bound words 0x1000 to 0x1100
      pmp_addr_i[1] = 32'h0000_1000;
      pmp_addr_i[2] = 32'h0000_1100;
      pmp_cfg_i[2]  = make_cfg(TOR, 1'b0, 1'b1, 1'b1);
      // Entry 3 is a read-only word at byte 0x8000
      pmp_addr_i[3] = 32'h0000_2000;
      pmp_cfg_i[3]  = make_cfg(NA4, 1'b0, 1'b0, 1'b1);
      check_data("na4 read", 32'h0000_8000, 1'b0, 1'b1);
      check_data("na4 write", 32'h0000_8000, 1'b1, 1'b0);
      check_data("na4 next word", 32'h0000_8004, 1'b0, 1'b0);
      check_data("tor lower bound", 32'h0000_4000, 1'b1, 1'b1);
      check_data("tor last word", 32'h0000_43fc, 1'b0, 1'b1);
      check_data("tor upper bound", 32'h0000_4400, 1'b0, 1'b0);
      check_data("tor0 from zero", 32'h0000_0000, 1'b0, 1'b1);
      check_data("tor0 at top", 32'h0000_0100, 1'b0, 1'b0);
      report_test("na4 and tor");
   endtask

   task automatic test_napot();
      int          t;
      logic [31:0] base;
      logic [31:0] size;
      test_start   = errors;
      priv_i       = PRIV_LVL_U;
      pmp_cfg_i    = '0;
      pmp_addr_i   = '0;
      pmp_cfg_i[0] = make_cfg(NAPOT, 1'b0, 1'b0, 1'b1);
      for (int n = 0; n < 20; n++)
      begin
         // t trailing ones select a region of 2^(t+1) words
         t             = int'(next_rand() % 32'd24);
         size          = 32'd1 << (t + 1);
         base          = next_rand() & 32'h3fff_ffff & ~(size - 32'd1);
         pmp_addr_i[0] = base | ((size >> 1) - 32'd1);
         check_data($sformatf("napot %0d first", n), base << 2, 1'b0, 1'b1);
         check_data($sformatf("napot %0d last", n), (base + size - 32'd1) << 2, 1'b0, 1'b1);
         if (base != 32'd0)
         begin
            check_data($sformatf("napot %0d below", n), (base - 32'd1) << 2, 1'b0, 1'b0);
         end
         if (base + size < 32'h4000_0000)
         begin
            check_data($sformatf("napot %0d above", n), (base + size) << 2, 1'b0, 1'b0);
         end
      end
      // No zero bit left, so the entry matches nothing
      pmp_addr_i[0] = '1;
      check_data("napot all ones", next_rand(), 1'b0, 1'b0);
      check_data("napot all ones top", 32'hffff_fffc, 1'b0, 1'b0);
      report_test("napot sizes");
   endtask

   task automatic test_data_error();
      test_start = errors;
      priv_i     = PRIV_LVL_U;
      pmp_cfg_i  = '0;
      // Acknowledge whatever earlier denied accesses left behind
      data_err_ack_i = 1'b1;
      end_cycle();
      data_err_ack_i = 1'b0;
      data_req_i     = 1'b1;
      data_we_i      = 1'b0;
      data_addr_i    = next_rand();
      data_gnt_i     = 1'b1;
      #SAMPLE_DLY;
      check_bit("deny req", 1'b0, data_req_o);
      check_bit("deny gnt", 1'b0, data_gnt_o);
      check_bit("err before edge", 1'b0, data_err_o);
      end_cycle();
      data_req_i = 1'b0;
      #SAMPLE_DLY;
      check_bit("err raised", 1'b1, data_err_o);
      end_cycle();
      #SAMPLE_DLY;
      check_bit("err held", 1'b1, data_err_o);
      end_cycle();
      data_err_ack_i = 1'b1;
      #SAMPLE_DLY;
      check_bit("err held until ack edge", 1'b1, data_err_o);
      end_cycle();
      data_err_ack_i = 1'b0;
      #SAMPLE_DLY;
      check_bit("err cleared", 1'b0, data_err_o);
      end_cycle();
      report_test("data error");
   endtask

   task automatic test_fetch();
      test_start = errors;
      priv_i     = PRIV_LVL_U;
      pmp_cfg_i  = '0;
      pmp_addr_i = '0;
      // 512 words from byte 0x4000_0000, readable and writable only
      pmp_addr_i[0] = 32'h1000_00ff;
      pmp_cfg_i[0]  = make_cfg(NAPOT, 1'b0, 1'b1, 1'b1);
      // One executable word at byte 0x8000_0000
      pmp_addr_i[1] = 32'h2000_0000;
      pmp_cfg_i[1]  = make_cfg(NA4, 1'b1, 1'b0, 1'b0);
      instr_req_i   = 1'b1;
      instr_addr_i  = 32'h4000_0100;
      instr_gnt_i   = 1'b1;
      #SAMPLE_DLY;
      check_bit("fetch no x err", 1'b1, instr_err_o);
      check_bit("fetch no x req", 1'b0, instr_req_o);
      check_bit("fetch no x gnt", 1'b0, instr_gnt_o);
      end_cycle();
      instr_addr_i = 32'h8000_0000;
      instr_gnt_i  = 1'b0;
      repeat (3)
      begin
         #SAMPLE_DLY;
         check_bit("fetch stall req", 1'b1, instr_req_o);
         check_bit("fetch stall gnt", 1'b0, instr_gnt_o);
         check_bit("fetch stall err", 1'b0, instr_err_o);
         end_cycle();
      end
      instr_gnt_i = 1'b1;
      #SAMPLE_DLY;
      check_bit("fetch granted", 1'b1, instr_gnt_o);
      check_addr("fetch addr", 32'h8000_0000, instr_addr_o);
      end_cycle();
      instr_req_i = 1'b0;
      report_test("fetch side");
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial
   begin
      lcg_state      = 32'h136f_c6c7;
      errors         = 0;
      checks         = 0;
      tests          = 0;
      test_start     = 0;
      rst_n          = 1'b0;
      priv_i         = PRIV_LVL_M;
      pmp_cfg_i      = '0;
      pmp_addr_i     = '0;
      data_req_i     = 1'b0;
      data_we_i      = 1'b0;
      data_addr_i    = '0;
      data_gnt_i     = 1'b0;
      data_err_ack_i = 1'b0;
      instr_req_i    = 1'b0;
      instr_addr_i   = '0;
      instr_gnt_i    = 1'b0;
      repeat (8) @(posedge clk);
      #DRIVE_DLY;
      rst_n = 1'b1;
      test_machine_bypass();
      test_na4_tor();
      test_napot();
      test_data_error();
      test_fetch();
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
      begin
         $display("RESULT: PASS");
      end
      else
      begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* all.f */
pmp_pkg.sv
pmp_rule_decode.sv
pmp_access_check.sv
pmp_data_gate.sv
pmp_top.sv
tb_pmp.sv

/* Makefile */
# Verilator simulation of the PMP unit
VERILATOR ?= verilator
TOP       ?= tb_pmp
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf $(OBJ_DIR)
